// ==== design/csi2_rx_cfg.svh ====
`ifndef CSI2_RX_CFG_SVH
`define CSI2_RX_CFG_SVH

// ====================
// datapath widths
// ====================
`define CSI2_BYTE_W 8
`define CSI2_WORD_W 40
`define CSI2_PX_W   10

// ====================
// register port
// ====================
`define CSI2_WB_AW 2
`define CSI2_WB_DW 32

`define CSI2_REG_LINE_PX   2'd0
`define CSI2_REG_LINE_CNT  2'd1
`define CSI2_REG_FRAME_CNT 2'd2
`define CSI2_REG_CTRL      2'd3

`endif

// ==== design/csi2_rx_pkg.sv ====
`include "csi2_rx_cfg.svh"

package csi2_rx_pkg;

  // ====================
  // stream beats
  // ====================
  typedef struct packed {
    logic [`CSI2_BYTE_W-1:0] data;
    logic                    last;  // last payload byte of the line.
  } byte_beat_t;

  typedef struct packed {
    logic [`CSI2_WORD_W-1:0] data;  // four msb bytes, then the lsb byte.
    logic                    last;
  } word_beat_t;

  typedef struct packed {
    logic [`CSI2_PX_W-1:0] data;
    logic                  last;    // end of line.
    logic                  sof;     // first pixel of a frame.
  } px_beat_t;

  // ====================
  // wishbone
  // ====================
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`CSI2_WB_AW-1:0] adr;
    logic [`CSI2_WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                   ack;
    logic [`CSI2_WB_DW-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    PX_0_S,
    PX_1_S,
    PX_2_S,
    PX_3_S
  } px_state_e;

  typedef enum logic [`CSI2_WB_AW-1:0] {
    REG_LINE_PX   = `CSI2_REG_LINE_PX,
    REG_LINE_CNT  = `CSI2_REG_LINE_CNT,
    REG_FRAME_CNT = `CSI2_REG_FRAME_CNT,
    REG_CTRL      = `CSI2_REG_CTRL
  } reg_addr_e;

endpackage

// ==== design/csi2_raw10_packer.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_raw10_packer
(
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  csi2_rx_pkg::byte_beat_t byte_i,
  input  logic                    byte_valid_i,
  output logic                    byte_ready_o,
  output csi2_rx_pkg::word_beat_t word_o,
  output logic                    word_valid_o,
  input  logic                    word_ready_i
);

localparam int LANES = `CSI2_WORD_W / `CSI2_BYTE_W;

logic [2:0]              lane;
logic [`CSI2_WORD_W-1:0] fill_q;
logic                    grp_done;
logic                    grp_last;
logic                    byte_acc;
logic                    fifth_acc;
logic                    word_load;
logic [`CSI2_WORD_W-1:0] word_data_q;
logic                    word_last_q;
logic                    word_valid_q;

assign byte_ready_o = !word_valid_q || word_ready_i;  // word slot empty or leaving now.
assign byte_acc     = byte_valid_i && byte_ready_o;
assign fifth_acc    = byte_acc && ( lane == 3'( LANES - 1 ) );
assign word_load    = grp_done && byte_ready_o;

// ====================
// group fill
// ====================
always_ff @( posedge clk_i )
  if( srst_i )
    lane <= '0;
  else
    if( byte_acc )
      lane <= fifth_acc ? 3'd0 : lane + 3'd1;

always_ff @( posedge clk_i )
  if( byte_acc )
    fill_q[lane * `CSI2_BYTE_W +: `CSI2_BYTE_W] <= byte_i.data;

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      grp_done <= 1'b0;
      grp_last <= 1'b0;
    end
  else
    if( fifth_acc )
      begin
        grp_done <= 1'b1;
        grp_last <= byte_i.last;
      end
    else
      if( word_load )
        grp_done <= 1'b0;

// ====================
// word register
// ====================
always_ff @( posedge clk_i )
  if( word_load )
    word_data_q <= fill_q;  // next group may already be filling lane 0.

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      word_valid_q <= 1'b0;
      word_last_q  <= 1'b0;
    end
  else
    if( word_load )
      begin
        word_valid_q <= 1'b1;
        word_last_q  <= grp_last;
      end
    else
      if( word_ready_i )
        word_valid_q <= 1'b0;

assign word_o       = '{data: word_data_q, last: word_last_q};
assign word_valid_o = word_valid_q;

// a line is a whole number of groups.
last_on_fifth_byte: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  byte_valid_i && byte_ready_o && byte_i.last |-> lane == 3'( LANES - 1 ) );

endmodule

// ==== design/csi2_px_serializer.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_px_serializer
(
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  logic                    frame_start_i,
  input  csi2_rx_pkg::word_beat_t word_i,
  input  logic                    word_valid_i,
  output logic                    word_ready_o,
  output csi2_rx_pkg::px_beat_t   px_o,
  output logic                    px_valid_o,
  input  logic                    px_ready_i
);

csi2_rx_pkg::px_state_e  state;
csi2_rx_pkg::px_state_e  next_state;
logic [`CSI2_WORD_W-1:0] word_q;
logic [`CSI2_WORD_W-1:0] src_word;
logic                    last_word;
logic                    start_flag;
logic                    out_free;
logic                    word_acc;
logic                    px_load;
logic [`CSI2_PX_W-1:0]   px_data;
logic [`CSI2_PX_W-1:0]   px_data_q;
logic                    px_valid_q;
logic                    px_last_q;
logic                    px_sof_q;

// pixel k is msb byte k with lsb pair k below it.
function automatic logic [`CSI2_PX_W-1:0] raw10_px
(
  input logic [`CSI2_WORD_W-1:0] w,
  input logic [1:0]              k
);
  raw10_px = { w[k * `CSI2_BYTE_W +: `CSI2_BYTE_W], w[32 + k * 2 +: 2] };
endfunction

assign out_free     = !px_valid_q || px_ready_i;
assign word_ready_o = ( state == csi2_rx_pkg::PX_0_S ) && out_free;
assign word_acc     = word_valid_i && word_ready_o;
assign px_load      = ( state == csi2_rx_pkg::PX_0_S ) ? word_acc : px_ready_i;
assign src_word     = ( state == csi2_rx_pkg::PX_0_S ) ? word_i.data : word_q;
assign px_data      = raw10_px( src_word, state );

// ====================
// frame and line flags
// ====================
always_ff @( posedge clk_i )
  if( srst_i )
    start_flag <= 1'b0;
  else
    if( frame_start_i )
      start_flag <= 1'b1;
    else
      if( word_acc )
        start_flag <= 1'b0;  // pixel 0 of this word takes the mark.

always_ff @( posedge clk_i )
  if( srst_i )
    last_word <= 1'b0;
  else
    if( word_acc )
      last_word <= word_i.last;

always_ff @( posedge clk_i )
  if( word_acc )
    word_q <= word_i.data;

// ====================
// pixel phase FSM
// ====================
always_ff @( posedge clk_i )
  if( srst_i )
    state <= csi2_rx_pkg::PX_0_S;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      csi2_rx_pkg::PX_0_S:
        begin
          if( word_acc )
            next_state = csi2_rx_pkg::PX_1_S;
        end
      csi2_rx_pkg::PX_1_S:
        begin
          if( px_ready_i )
            next_state = csi2_rx_pkg::PX_2_S;
        end
      csi2_rx_pkg::PX_2_S:
        begin
          if( px_ready_i )
            next_state = csi2_rx_pkg::PX_3_S;
        end
      csi2_rx_pkg::PX_3_S:
        begin
          if( px_ready_i )
            next_state = csi2_rx_pkg::PX_0_S;
        end
      default:
        next_state = csi2_rx_pkg::PX_0_S;
    endcase
  end

// ====================
// output register
// ====================
always_ff @( posedge clk_i )
  if( px_load )
    px_data_q <= px_data;

always_ff @( posedge clk_i )
  if( srst_i )
    begin
      px_valid_q <= 1'b0;
      px_last_q  <= 1'b0;
      px_sof_q   <= 1'b0;
    end
  else
    if( px_load )
      begin
        px_valid_q <= 1'b1;
        px_last_q  <= ( state == csi2_rx_pkg::PX_3_S ) && last_word;
        px_sof_q   <= ( state == csi2_rx_pkg::PX_0_S ) && start_flag;
      end
    else
      if( px_ready_i )
        begin
          px_valid_q <= 1'b0;
          px_last_q  <= 1'b0;
          px_sof_q   <= 1'b0;
        end

assign px_o       = '{data: px_data_q, last: px_last_q, sof: px_sof_q};
assign px_valid_o = px_valid_q;

px_hold_on_stall: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  px_valid_o && !px_ready_i |=> px_valid_o && $stable( px_o ) );

// an offered word stays put until this block takes it.
word_held_on_stall: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  word_valid_i && !word_ready_o |=> word_valid_i && $stable( word_i ) );

endmodule

// ==== design/csi2_px_stats.sv ====
`timescale 1ns/1ps
`include "csi2_rx_cfg.svh"

module csi2_px_stats
(
  input  logic                   clk_i,
  input  logic                   srst_i,
  input  csi2_rx_pkg::px_beat_t  px_i,
  input  logic                   px_fire_i,
  input  csi2_rx_pkg::wb_req_t   wb_i,
  output csi2_rx_pkg::wb_rsp_t   wb_o
);

csi2_rx_pkg::reg_addr_e reg_sel;
logic [`CSI2_WB_DW-1:0] px_run;
logic [`CSI2_WB_DW-1:0] line_px;
logic [`CSI2_WB_DW-1:0] line_cnt;
logic [`CSI2_WB_DW-1:0] frame_cnt;
logic [`CSI2_WB_DW-1:0] rd_data;
logic [`CSI2_WB_DW-1:0] rd_data_q;
logic                   ack_q;
logic                   wb_req;
logic                   clr;

assign reg_sel = csi2_rx_pkg::reg_addr_e'( wb_i.adr );
assign wb_req  = wb_i.cyc && wb_i.stb;
assign clr     = ack_q && wb_req && wb_i.we &&
                 ( reg_sel == csi2_rx_pkg::REG_CTRL ) && wb_i.dat[0];  // write lands on ack.

// ====================
// counters
// ====================
always_ff @( posedge clk_i )
  if( srst_i || clr )
    begin
      px_run    <= '0;
      line_px   <= '0;
      line_cnt  <= '0;
      frame_cnt <= '0;
    end
  else
    if( px_fire_i )
      begin
        if( px_i.last )
          begin
            line_px <= px_run + 1'b1;  // count includes this pixel.
            px_run  <= '0;
          end
        else
          px_run <= px_run + 1'b1;
        line_cnt  <= ( px_i.sof ? '0 : line_cnt ) + px_i.last;
        frame_cnt <= frame_cnt + px_i.sof;
      end

// ====================
// register port
// ====================
always_comb
  begin
    rd_data = '0;
    case( reg_sel )
      csi2_rx_pkg::REG_LINE_PX:   rd_data = line_px;
      csi2_rx_pkg::REG_LINE_CNT:  rd_data = line_cnt;
      csi2_rx_pkg::REG_FRAME_CNT: rd_data = frame_cnt;
      default:                    rd_data = '0;  // CTRL reads back zero.
    endcase
  end

always_ff @( posedge clk_i )
  if( srst_i )
    ack_q <= 1'b0;
  else
    ack_q <= wb_req && !ack_q;  // one ack per request.

always_ff @( posedge clk_i )
  if( wb_req && !ack_q )
    rd_data_q <= rd_data;

assign wb_o = '{ack: ack_q, dat: rd_data_q};

// the master keeps cyc and stb up until it has seen ack.
req_held_until_ack: assert property ( @( posedge clk_i ) disable iff ( srst_i )
  wb_req && !wb_o.ack |=> wb_req );

endmodule

// ==== design/csi2_raw10_rx.sv ====
`timescale 1ns/1ps

module csi2_raw10_rx
(
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  logic                    frame_start_i,
  input  csi2_rx_pkg::byte_beat_t in_byte_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output csi2_rx_pkg::px_beat_t   px_o,
  output logic                    px_valid_o,
  input  logic                    px_ready_i,
  input  csi2_rx_pkg::wb_req_t    wb_i,
  output csi2_rx_pkg::wb_rsp_t    wb_o
);

csi2_rx_pkg::word_beat_t word;
logic                    word_valid;
logic                    word_ready;
logic                    px_fire;

assign px_fire = px_valid_o && px_ready_i;

csi2_raw10_packer packer
(
  .clk_i        ( clk_i      ),
  .srst_i       ( srst_i     ),
  .byte_i       ( in_byte_i  ),
  .byte_valid_i ( in_valid_i ),
  .byte_ready_o ( in_ready_o ),
  .word_o       ( word       ),
  .word_valid_o ( word_valid ),
  .word_ready_i ( word_ready )
);

csi2_px_serializer serializer
(
  .clk_i         ( clk_i         ),
  .srst_i        ( srst_i        ),
  .frame_start_i ( frame_start_i ),
  .word_i        ( word          ),
  .word_valid_i  ( word_valid    ),
  .word_ready_o  ( word_ready    ),
  .px_o          ( px_o          ),
  .px_valid_o    ( px_valid_o    ),
  .px_ready_i    ( px_ready_i    )
);

csi2_px_stats stats
(
  .clk_i     ( clk_i   ),
  .srst_i    ( srst_i  ),
  .px_i      ( px_o    ),
  .px_fire_i ( px_fire ),
  .wb_i      ( wb_i    ),
  .wb_o      ( wb_o    )
);

endmodule

// ==== dv/csi2_rx_model.svh ====
`ifndef CSI2_RX_MODEL_SVH
`define CSI2_RX_MODEL_SVH

// ====================
// reference model
// ====================
csi2_rx_pkg::px_beat_t exp_px_q[$];  // expected pixels in output order.
logic [7:0]            grp_bytes[$];
bit                    sof_pending;
int                    exp_lines;    // lines since frame start or clear.
int                    exp_frames;   // frames since reset or clear.

function automatic void model_reset();
  exp_px_q.delete();
  grp_bytes.delete();
  sof_pending = 1'b0;
  exp_lines   = 0;
  exp_frames  = 0;
endfunction

function automatic void model_frame_start();
  sof_pending = 1'b1;
  exp_lines   = 0;
  exp_frames++;
endfunction

// five bytes make a group: four msb bytes, then the lsb pairs with pixel 0 in bits 1:0.
function automatic void model_push_byte( input logic [7:0] data, input logic last );
  csi2_rx_pkg::px_beat_t p;
  int                    k;
  grp_bytes.push_back( data );
  if( grp_bytes.size() == 5 )
    begin
      for( k = 0; k < 4; k++ )
        begin
          p.data = { grp_bytes[k], grp_bytes[4][2*k +: 2] };
          p.last = last && ( k == 3 );
          p.sof  = sof_pending && ( k == 0 );
          exp_px_q.push_back( p );
        end
      sof_pending = 1'b0;
      grp_bytes.delete();
    end
endfunction

function automatic void model_clear();
  exp_lines  = 0;
  exp_frames = 0;
endfunction

`endif

// ==== dv/csi2_raw10_rx_tb.sv ====
`timescale 1ns/1ps

module csi2_raw10_rx_tb;

localparam logic [31:0] SEED      = 32'hb214_6708;
localparam int          FRAMES    = 4;
localparam int          MAX_LINES = 4;
localparam int          MAX_GRPS  = 12;
localparam int          READY_LEN = 1000;

logic                    clk;
logic                    srst;
logic                    frame_start;
csi2_rx_pkg::byte_beat_t in_byte;
logic                    in_valid;
logic                    in_ready;
csi2_rx_pkg::px_beat_t   px;
logic                    px_valid;
logic                    px_ready;
csi2_rx_pkg::wb_req_t    wb_req;
csi2_rx_pkg::wb_rsp_t    wb_rsp;

int line_groups [FRAMES][MAX_LINES];
int frame_lines [FRAMES];
bit ready_pattern [READY_LEN];
int total_bytes   = 0;
int timeout_limit = 0;
int cycle_count   = 0;
int ack_count     = 0;

`include "csi2_rx_model.svh"

csi2_raw10_rx dut
(
  .clk_i         ( clk         ),
  .srst_i        ( srst        ),
  .frame_start_i ( frame_start ),
  .in_byte_i     ( in_byte     ),
  .in_valid_i    ( in_valid    ),
  .in_ready_o    ( in_ready    ),
  .px_o          ( px          ),
  .px_valid_o    ( px_valid    ),
  .px_ready_i    ( px_ready    ),
  .wb_i          ( wb_req      ),
  .wb_o          ( wb_rsp      )
);

// ====================
// clock and watchers
// ====================
initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

always @( posedge clk )
  begin
    cycle_count++;
    if( timeout_limit > 0 && cycle_count > timeout_limit )
      begin
        $display( "Timeout: the run did not finish within %0d cycles.", timeout_limit );
        $display( "Checks failed" );
        $fatal( 1, "simulation stopped on timeout" );
      end
  end

always @( negedge clk )
  if( wb_rsp.ack )
    ack_count++;

// output back-pressure replays a pattern drawn at the start.
initial
  begin
    px_ready = 1'b0;
    forever
      begin
        @( negedge clk );
        px_ready = ready_pattern[cycle_count % READY_LEN];
      end
  end

// ====================
// checks and bus tasks
// ====================
task automatic check_value( input string name, input logic [31:0] got, input logic [31:0] exp );
  if( got !== exp )
    begin
      $display( "[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp );
      $display( "Checks failed" );
      $fatal( 1, "stopped at the first mismatch" );
    end
endtask

task automatic compare_pixel();
  csi2_rx_pkg::px_beat_t exp_px;
  if( exp_px_q.size() == 0 )
    begin
      $display( "A pixel left the DUT at %0t ns with no pixel left in the model.", $time );
      $display( "Checks failed" );
      $fatal( 1, "pixel without a matching input group" );
    end
  else
    begin
      exp_px = exp_px_q.pop_front();
      check_value( "px_o.data", px.data, exp_px.data );
      check_value( "px_o.last", px.last, exp_px.last );
      check_value( "px_o.sof", px.sof, exp_px.sof );
    end
endtask

// handshakes are sampled once the falling-edge inputs have settled.
always @( negedge clk )
  begin
    #1;
    if( !srst && px_valid && px_ready )
      compare_pixel();
  end

task automatic wb_access
(
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);
  int acks_before;
  acks_before = ack_count;
  wb_req.cyc  = 1'b1;
  wb_req.stb  = 1'b1;
  wb_req.we   = we;
  wb_req.adr  = adr;
  wb_req.dat  = wdata;
  @( negedge clk );
  while( !wb_rsp.ack )
    @( negedge clk );
  rdata = wb_rsp.dat;
  @( negedge clk );  // request stays up through the ack edge.
  wb_req = '0;
  repeat( 2 ) @( negedge clk );
  check_value( "wb_o.ack pulses", ack_count - acks_before, 1 );
endtask

task automatic read_reg( input logic [1:0] adr, input string name, input int exp );
  logic [31:0] rdata;
  wb_access( 1'b0, adr, 32'd0, rdata );
  check_value( name, rdata, exp );
endtask

task automatic read_counters( input int exp_line_px );
  read_reg( csi2_rx_pkg::REG_LINE_PX, "wb_o.dat LINE_PX", exp_line_px );
  read_reg( csi2_rx_pkg::REG_LINE_CNT, "wb_o.dat LINE_CNT", exp_lines );
  read_reg( csi2_rx_pkg::REG_FRAME_CNT, "wb_o.dat FRAME_CNT", exp_frames );
endtask

task automatic send_line( input int nbytes );
  int n;
  for( n = 0; n < nbytes; n++ )
    begin
      while( $urandom_range( 0, 3 ) == 0 )
        begin
          in_valid = 1'b0;
          @( negedge clk );
        end
      in_byte.data = 8'( $urandom );
      in_byte.last = ( n == nbytes - 1 );
      in_valid     = 1'b1;
      #1;
      while( !in_ready )
        begin
          @( negedge clk );
          #1;
        end
      model_push_byte( in_byte.data, in_byte.last );  // accepted on the coming edge.
      @( negedge clk );
    end
  in_valid = 1'b0;
endtask

task automatic wait_drain();
  while( exp_px_q.size() != 0 )
    @( negedge clk );
endtask

// ====================
// test sequence
// ====================
initial
  begin
    logic [31:0] rdata;
    int          f;
    int          l;
    void'( $urandom( SEED ) );
    srst        = 1'b1;
    frame_start = 1'b0;
    in_byte     = '0;
    in_valid    = 1'b0;
    wb_req      = '0;
    model_reset();
    for( f = 0; f < FRAMES; f++ )
      begin
        frame_lines[f] = $urandom_range( 2, MAX_LINES );
        for( l = 0; l < frame_lines[f]; l++ )
          begin
            line_groups[f][l] = $urandom_range( 1, MAX_GRPS );
            total_bytes += line_groups[f][l] * 5;
          end
      end
    for( f = 0; f < READY_LEN; f++ )
      ready_pattern[f] = ( $urandom_range( 0, 9 ) < 7 );
    timeout_limit = 4 * total_bytes + 2000;
    repeat( 16 ) @( negedge clk );
    srst = 1'b0;
    @( negedge clk );
    check_value( "px_valid_o", px_valid, 0 );
    check_value( "in_ready_o", in_ready, 1 );
    read_counters( 0 );
    read_reg( csi2_rx_pkg::REG_CTRL, "wb_o.dat CTRL", 0 );
    for( f = 0; f < FRAMES; f++ )
      begin
        frame_start = 1'b1;  // pipeline is empty here.
        @( negedge clk );
        frame_start = 1'b0;
        model_frame_start();
        for( l = 0; l < frame_lines[f]; l++ )
          begin
            send_line( line_groups[f][l] * 5 );
            wait_drain();
            exp_lines++;
            read_counters( line_groups[f][l] * 5 * 4 / 5 );
            if( f == 1 && l == 0 )
              begin
                wb_access( 1'b1, csi2_rx_pkg::REG_CTRL, 32'd1, rdata );
                model_clear();
                read_counters( 0 );
              end
          end
      end
    check_value( "px_valid_o", px_valid, 0 );  // no stray pixel after the last line.
    $display( "All checks passed" );
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
+incdir+dv
design/csi2_rx_pkg.sv
design/csi2_raw10_packer.sv
design/csi2_px_serializer.sv
design/csi2_px_stats.sv
design/csi2_raw10_rx.sv
dv/csi2_raw10_rx_tb.sv

// ==== Makefile ====
TOP := csi2_raw10_rx_tb

.PHONY: lint sim clean

# Width warnings are printed but do not stop the build.
lint:
	verilator --lint-only --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

# The run passes only when the pass message shows up in the output.
sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
